// ==== Bender.yml ====
package:
  name: sfu

sources:
  - hw/sfu_pkg.sv
  - hw/sfu_ctrl.sv
  - hw/sfu_read_seq.sv
  - hw/sfu_splice_acc.sv
  - hw/sfu_activation.sv
  - hw/sfu_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_sfu.sv

// ==== hw/sfu_activation.sv ====
module sfu_activation #(
    parameter int LANES = sfu_pkg::LANES_DEF
) (
    input  logic                       clk,
    input  logic                       RSTn,
    input  logic                       clear_i,
    input  logic                       act_en_i,
    input  sfu_pkg::act_kind_e         act_kind_i,
    input  sfu_pkg::acc_t [LANES-1:0]  acc_i,
    output sfu_pkg::acc_t [LANES-1:0]  result_o
);

    sfu_pkg::acc_t [LANES-1:0] act_val;
    sfu_pkg::acc_t [LANES-1:0] result_q;

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            if (act_kind_i == sfu_pkg::ACT_RELU) begin
                // negative columns are cut to zero
                act_val[l] = acc_i[l][sfu_pkg::ACC_W-1] ? '0 : acc_i[l];
            end else begin
                // step fires only on a strictly positive sum
                act_val[l] = (acc_i[l] > 0) ? sfu_pkg::acc_t'(1) : '0;
            end
        end
    end

    // result is held until the next clean or activation
    always_ff @(posedge clk) begin
        if (RSTn || clear_i) begin
            result_q <= '0;
        end else if (act_en_i) begin
            result_q <= act_val;
        end
    end

    assign result_o = result_q;

endmodule

// ==== hw/sfu_ctrl.sv ====
module sfu_ctrl (
    input  logic                 clk,
    input  logic                 RSTn,
    input  sfu_pkg::sfu_cmd_e    cmd_i,
    input  logic                 last_word_i,
    output logic                 clear_o,
    output logic                 start_o,
    output logic                 act_en_o,
    output sfu_pkg::act_kind_e   act_kind_o,
    output logic                 done_o
);

    typedef enum logic [1:0] {
        PH_EMPTY    = 2'd0,
        PH_LOADING  = 2'd1,
        PH_LOADED   = 2'd2,
        PH_FINISHED = 2'd3
    } phase_e;

    phase_e phase_q;
    logic   start_q;
    logic   done_q;
    logic   is_act;

    // clean acts for as long as the host holds it
    assign clear_o = (cmd_i == sfu_pkg::CMD_CLEAN);

    assign is_act = (cmd_i == sfu_pkg::CMD_ACT_HIDDEN) ||
                    (cmd_i == sfu_pkg::CMD_ACT_OUTPUT);

    // only a loaded image may be activated, and only once
    assign act_en_o   = is_act && (phase_q == PH_LOADED);
    assign act_kind_o = (cmd_i == sfu_pkg::CMD_ACT_OUTPUT) ? sfu_pkg::ACT_RELU
                                                           : sfu_pkg::ACT_STEP;

    assign start_o = start_q;
    assign done_o  = done_q;

    always_ff @(posedge clk) begin
        if (RSTn) begin
            phase_q <= PH_EMPTY;
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (clear_o) begin
                phase_q <= PH_EMPTY;
                done_q  <= 1'b0;
            end else begin
                case (phase_q)
                    PH_EMPTY: begin
                        if (cmd_i == sfu_pkg::CMD_LOAD) begin
                            phase_q <= PH_LOADING;
                            start_q <= 1'b1;
                        end
                    end
                    PH_LOADING: begin
                        // last word is summed on this same edge
                        if (last_word_i) begin
                            phase_q <= PH_LOADED;
                            done_q  <= 1'b1;
                        end
                    end
                    PH_LOADED: begin
                        if (act_en_o) begin
                            phase_q <= PH_FINISHED;
                            done_q  <= 1'b1;
                        end
                    end
                    default: begin
                        phase_q <= phase_q;
                    end
                endcase
                if (cmd_i == sfu_pkg::CMD_IDLE) begin
                    done_q <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== hw/sfu_pkg.sv ====
package sfu_pkg;

    // default sizes, overridden from sfu_top
    localparam int LANES_DEF       = 8;
    localparam int MACROS_DEF      = 4;
    localparam int TIME_FRAMES_DEF = 8;

    // one partial sum as stored in shared memory
    localparam int PSUM_W = 8;
    // one spliced column
    localparam int ACC_W  = 16;

    // host command, held as a level
    typedef enum logic [2:0] {
        CMD_CLEAN      = 3'd0,
        CMD_ACT_HIDDEN = 3'd1,
        CMD_ACT_OUTPUT = 3'd3,
        CMD_LOAD       = 3'd4,
        CMD_IDLE       = 3'd5
    } sfu_cmd_e;

    typedef logic signed [ACC_W-1:0] acc_t;

    // which macros and which window of time frames are spliced
    typedef struct packed {
        logic [MACROS_DEF-1:0]               macro_mask;
        logic [$clog2(TIME_FRAMES_DEF)-1:0]  time_first;
        logic [$clog2(TIME_FRAMES_DEF)-1:0]  time_last;
    } splice_cfg_t;

    // step for hidden layers, relu for the output layer
    typedef enum logic {
        ACT_STEP = 1'b0,
        ACT_RELU = 1'b1
    } act_kind_e;

endpackage

// ==== hw/sfu_read_seq.sv ====
module sfu_read_seq #(
    parameter int  MACROS      = sfu_pkg::MACROS_DEF,
    parameter int  TIME_FRAMES = sfu_pkg::TIME_FRAMES_DEF,
    localparam int WORDS       = MACROS * TIME_FRAMES,
    localparam int ADDR_W      = (WORDS > 1) ? $clog2(WORDS) : 1,
    localparam int MACRO_W     = (MACROS > 1) ? $clog2(MACROS) : 1,
    localparam int TIME_W      = (TIME_FRAMES > 1) ? $clog2(TIME_FRAMES) : 1
) (
    input  logic               clk,
    input  logic               RSTn,
    input  logic               start_i,
    output logic               rd_en_o,
    output logic [ADDR_W-1:0]  rd_addr_o,
    output logic               word_valid_o,
    output logic [MACRO_W-1:0] word_macro_o,
    output logic [TIME_W-1:0]  word_time_o,
    output logic               last_word_o
);

    localparam logic [ADDR_W-1:0]  LAST_ADDR  = ADDR_W'(WORDS - 1);
    localparam logic [MACRO_W-1:0] LAST_MACRO = MACRO_W'(MACROS - 1);

    logic               rd_en_q;
    logic [ADDR_W-1:0]  addr_q;
    logic [MACRO_W-1:0] macro_q;
    logic [TIME_W-1:0]  time_q;
    logic               valid_q;
    logic               last_q;
    logic [MACRO_W-1:0] tag_macro_q;
    logic [TIME_W-1:0]  tag_time_q;

    // word counter, k = time * MACROS + macro
    always_ff @(posedge clk) begin
        if (RSTn) begin
            rd_en_q <= 1'b0;
            addr_q  <= '0;
            macro_q <= '0;
            time_q  <= '0;
        end else if (start_i) begin
            rd_en_q <= 1'b1;
            addr_q  <= '0;
            macro_q <= '0;
            time_q  <= '0;
        end else if (rd_en_q) begin
            if (addr_q == LAST_ADDR) begin
                rd_en_q <= 1'b0;
                addr_q  <= '0;
                macro_q <= '0;
                time_q  <= '0;
            end else begin
                addr_q <= addr_q + 1'b1;
                if (macro_q == LAST_MACRO) begin
                    macro_q <= '0;
                    time_q  <= time_q + 1'b1;
                end else begin
                    macro_q <= macro_q + 1'b1;
                end
            end
        end
    end

    // memory answers one cycle late, so tags follow by one cycle
    always_ff @(posedge clk) begin
        if (RSTn) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= rd_en_q;
            last_q  <= rd_en_q && (addr_q == LAST_ADDR);
        end
    end

    always_ff @(posedge clk) begin
        tag_macro_q <= macro_q;
        tag_time_q  <= time_q;
    end

    assign rd_en_o      = rd_en_q;
    assign rd_addr_o    = addr_q;
    assign word_valid_o = valid_q;
    assign word_macro_o = tag_macro_q;
    assign word_time_o  = tag_time_q;
    assign last_word_o  = last_q;

endmodule

// ==== hw/sfu_splice_acc.sv ====
module sfu_splice_acc #(
    parameter int  LANES   = sfu_pkg::LANES_DEF,
    parameter int  MACROS  = sfu_pkg::MACROS_DEF,
    localparam int MACRO_W = (MACROS > 1) ? $clog2(MACROS) : 1,
    localparam int TIME_W  = $clog2(sfu_pkg::TIME_FRAMES_DEF)
) (
    input  logic                              clk,
    input  logic                              RSTn,
    input  logic                              clear_i,
    input  sfu_pkg::splice_cfg_t              splice_cfg_i,
    input  logic                              word_valid_i,
    input  logic [MACRO_W-1:0]                word_macro_i,
    input  logic [TIME_W-1:0]                 word_time_i,
    input  logic [LANES*sfu_pkg::PSUM_W-1:0]  rd_data_i,
    output sfu_pkg::acc_t [LANES-1:0]         acc_o
);

    localparam int EXT_W = sfu_pkg::ACC_W - sfu_pkg::PSUM_W;

    sfu_pkg::acc_t [LANES-1:0] acc_q;
    sfu_pkg::acc_t [LANES-1:0] lane_ext;
    logic                      in_window;
    logic                      take;

    // sign-extend every lane of the returning word
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_ext[l] = {{EXT_W{rd_data_i[l*sfu_pkg::PSUM_W + sfu_pkg::PSUM_W - 1]}},
                           rd_data_i[l*sfu_pkg::PSUM_W +: sfu_pkg::PSUM_W]};
        end
    end

    assign in_window = (word_time_i >= splice_cfg_i.time_first) &&
                       (word_time_i <= splice_cfg_i.time_last);

    // word counts only if its macro is enabled and its frame is in range
    assign take = word_valid_i && splice_cfg_i.macro_mask[word_macro_i] && in_window;

    always_ff @(posedge clk) begin
        if (RSTn || clear_i) begin
            acc_q <= '0;
        end else if (take) begin
            for (int l = 0; l < LANES; l++) begin
                // wraps modulo 2^16
                acc_q[l] <= acc_q[l] + lane_ext[l];
            end
        end
    end

    assign acc_o = acc_q;

endmodule

// ==== hw/sfu_top.sv ====
module sfu_top #(
    parameter int  LANES       = sfu_pkg::LANES_DEF,
    parameter int  MACROS      = sfu_pkg::MACROS_DEF,
    parameter int  TIME_FRAMES = sfu_pkg::TIME_FRAMES_DEF,
    localparam int ADDR_W      = (MACROS * TIME_FRAMES > 1) ? $clog2(MACROS * TIME_FRAMES) : 1
) (
    input  logic                              clk,
    input  logic                              RSTn,
    input  sfu_pkg::sfu_cmd_e                 cmd_i,
    input  sfu_pkg::splice_cfg_t              splice_cfg_i,
    input  logic [LANES*sfu_pkg::PSUM_W-1:0]  rd_data_i,
    output logic                              rd_en_o,
    output logic [ADDR_W-1:0]                 rd_addr_o,
    output sfu_pkg::acc_t [LANES-1:0]         result_o,
    output logic                              done_o
);

    localparam int MACRO_W = (MACROS > 1) ? $clog2(MACROS) : 1;
    localparam int TIME_W  = (TIME_FRAMES > 1) ? $clog2(TIME_FRAMES) : 1;

    logic                      clear;
    logic                      start;
    logic                      act_en;
    sfu_pkg::act_kind_e        act_kind;
    logic                      word_valid;
    logic [MACRO_W-1:0]        word_macro;
    logic [TIME_W-1:0]         word_time;
    logic                      last_word;
    sfu_pkg::acc_t [LANES-1:0] acc_vec;

    // command decode and phase tracking
    sfu_ctrl u_ctrl (
        .clk         (clk),
        .RSTn        (RSTn),
        .cmd_i       (cmd_i),
        .last_word_i (last_word),
        .clear_o     (clear),
        .start_o     (start),
        .act_en_o    (act_en),
        .act_kind_o  (act_kind),
        .done_o      (done_o)
    );

    // shared memory reads in index order
    sfu_read_seq #(
        .MACROS      (MACROS),
        .TIME_FRAMES (TIME_FRAMES)
    ) u_read_seq (
        .clk          (clk),
        .RSTn         (RSTn),
        .start_i      (start),
        .rd_en_o      (rd_en_o),
        .rd_addr_o    (rd_addr_o),
        .word_valid_o (word_valid),
        .word_macro_o (word_macro),
        .word_time_o  (word_time),
        .last_word_o  (last_word)
    );

    // splicing of the selected partial sums
    sfu_splice_acc #(
        .LANES  (LANES),
        .MACROS (MACROS)
    ) u_splice_acc (
        .clk          (clk),
        .RSTn         (RSTn),
        .clear_i      (clear),
        .splice_cfg_i (splice_cfg_i),
        .word_valid_i (word_valid),
        .word_macro_i (word_macro),
        .word_time_i  (word_time),
        .rd_data_i    (rd_data_i),
        .acc_o        (acc_vec)
    );

    sfu_activation #(
        .LANES (LANES)
    ) u_activation (
        .clk        (clk),
        .RSTn       (RSTn),
        .clear_i    (clear),
        .act_en_i   (act_en),
        .act_kind_i (act_kind),
        .acc_i      (acc_vec),
        .result_o   (result_o)
    );

endmodule

// ==== src.f ====
hw/sfu_pkg.sv
hw/sfu_ctrl.sv
hw/sfu_read_seq.sv
hw/sfu_splice_acc.sv
hw/sfu_activation.sv
hw/sfu_top.sv
test/tb_clk_gen.sv
test/tb_sfu.sv

// ==== test/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD      = 40,
    parameter int RST_CYCLES  = 2
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // reset held high for the first rising edges
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// ==== test/tb_sfu.sv ====
module tb_sfu;

    localparam int LANES       = sfu_pkg::LANES_DEF;
    localparam int MACROS      = sfu_pkg::MACROS_DEF;
    localparam int TIME_FRAMES = sfu_pkg::TIME_FRAMES_DEF;
    localparam int WORDS       = MACROS * TIME_FRAMES;
    localparam int ADDR_W      = $clog2(WORDS);
    localparam int PSUM_W      = sfu_pkg::PSUM_W;
    localparam int NUM_ROWS    = 7;
    localparam int TIMEOUT     = NUM_ROWS * (2 * WORDS + 40);

    typedef sfu_pkg::acc_t [LANES-1:0] acc_vec_t;

    // one stimulus row
    typedef struct packed {
        sfu_pkg::splice_cfg_t cfg;
        sfu_pkg::sfu_cmd_e    act_cmd;
        logic                 act_early;
    } row_t;

    logic                      clk;
    logic                      RSTn;
    sfu_pkg::sfu_cmd_e         cmd;
    sfu_pkg::splice_cfg_t      splice_cfg;
    logic [LANES*PSUM_W-1:0]   rd_data;
    logic                      rd_en_o;
    logic [ADDR_W-1:0]         rd_addr_o;
    acc_vec_t                  result_o;
    logic                      done_o;

    logic [LANES*PSUM_W-1:0]   mem [WORDS];
    row_t                      rows [NUM_ROWS];
    int                        seed = 32'h9f7e_2bf2;
    int                        errors;
    int                        checks;
    int                        cycle_cnt;

    tb_clk_gen #(.PERIOD(40), .RST_CYCLES(2)) u_clk_gen (
        .clk_o (clk),
        .rst_o (RSTn)
    );

    sfu_top #(
        .LANES       (LANES),
        .MACROS      (MACROS),
        .TIME_FRAMES (TIME_FRAMES)
    ) u_dut (
        .clk          (clk),
        .RSTn         (RSTn),
        .cmd_i        (cmd),
        .splice_cfg_i (splice_cfg),
        .rd_data_i    (rd_data),
        .rd_en_o      (rd_en_o),
        .rd_addr_o    (rd_addr_o),
        .result_o     (result_o),
        .done_o       (done_o)
    );

    // shared memory answers one cycle after the read
    always @(posedge clk) begin
        if (rd_en_o) begin
            rd_data <= mem[rd_addr_o];
        end
    end

    function automatic row_t make_row(input logic [MACROS-1:0] mask, input int first,
                                      input int last, input sfu_pkg::sfu_cmd_e act_cmd,
                                      input logic early);
        row_t r;
        r.cfg.macro_mask = mask;
        r.cfg.time_first = first[2:0];
        r.cfg.time_last  = last[2:0];
        r.act_cmd        = act_cmd;
        r.act_early      = early;
        return r;
    endfunction

    // selected lanes summed mod 2^16, then step or relu
    function automatic acc_vec_t model_result(input row_t r);
        acc_vec_t         sums;
        acc_vec_t         res;
        logic [PSUM_W-1:0] lane;
        int               k;
        int               l;
        sums = '0;
        for (k = 0; k < WORDS; k++) begin
            if (r.cfg.macro_mask[k % MACROS] && (k / MACROS) >= r.cfg.time_first &&
                (k / MACROS) <= r.cfg.time_last) begin
                for (l = 0; l < LANES; l++) begin
                    lane    = mem[k][l*PSUM_W +: PSUM_W];
                    sums[l] = sums[l] + {{(sfu_pkg::ACC_W - PSUM_W){lane[PSUM_W-1]}}, lane};
                end
            end
        end
        for (l = 0; l < LANES; l++) begin
            res[l] = '0;
            if (r.act_cmd == sfu_pkg::CMD_ACT_OUTPUT) begin
                if (!sums[l][sfu_pkg::ACC_W-1]) begin
                    res[l] = sums[l];
                end
            end else if (!sums[l][sfu_pkg::ACC_W-1] && sums[l] != '0) begin
                // step gives 1 only for a positive non-zero sum
                res[l] = 16'd1;
            end
        end
        return res;
    endfunction

    task automatic check_acc_vec(input string name, input acc_vec_t exp, input acc_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // drive a command and wait until one edge has sampled it
    task automatic apply_cmd(input sfu_pkg::sfu_cmd_e c);
        @(posedge clk);
        cmd <= c;
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic run_load();
        int since;
        int rd_cycles;
        bit rd_gap;
        since     = 0;
        rd_cycles = 0;
        rd_gap    = 1'b0;
        apply_cmd(sfu_pkg::CMD_LOAD);
        while (!done_o) begin
            if (rd_en_o) begin
                if (rd_gap) begin
                    errors++;
                    $display("rd_en_o rose again after the read burst had ended");
                end
                check_addr("rd_addr_o", ADDR_W'(rd_cycles), rd_addr_o);
                rd_cycles++;
            end else if (rd_cycles > 0) begin
                rd_gap = 1'b1;
            end
            @(negedge clk);
            since++;
        end
        if (rd_cycles != WORDS) begin
            errors++;
            $display("rd_en_o was high for %0d cycles instead of %0d", rd_cycles, WORDS);
        end
        if (since != WORDS + 2) begin
            errors++;
            $display("done_o rose %0d cycles after the load, not %0d", since, WORDS + 2);
        end
        // load held after done must not start a second pass
        repeat (3) begin
            @(negedge clk);
            check_bit("rd_en_o", 1'b0, rd_en_o);
            check_bit("done_o", 1'b1, done_o);
        end
    endtask

    task automatic run_row(input int idx);
        acc_vec_t          expected;
        sfu_pkg::sfu_cmd_e other_cmd;
        int                err_start;
        int                k;
        err_start = errors;
        @(posedge clk);
        splice_cfg <= rows[idx].cfg;
        apply_cmd(sfu_pkg::CMD_CLEAN);
        check_acc_vec("result_o", '0, result_o);
        check_bit("done_o", 1'b0, done_o);
        for (k = 0; k < WORDS; k++) begin
            mem[k] = {$random(seed), $random(seed)};
        end
        expected = model_result(rows[idx]);
        if (rows[idx].act_early) begin
            apply_cmd(rows[idx].act_cmd);
            @(negedge clk);
            check_acc_vec("result_o", '0, result_o);
            check_bit("done_o", 1'b0, done_o);
        end
        run_load();
        apply_cmd(sfu_pkg::CMD_IDLE);
        check_bit("done_o", 1'b0, done_o);
        apply_cmd(rows[idx].act_cmd);
        check_bit("done_o", 1'b1, done_o);
        check_acc_vec("result_o", expected, result_o);
        // finished phase, the other activation kind must neither fire nor raise done
        if (rows[idx].act_cmd == sfu_pkg::CMD_ACT_OUTPUT) begin
            other_cmd = sfu_pkg::CMD_ACT_HIDDEN;
        end else begin
            other_cmd = sfu_pkg::CMD_ACT_OUTPUT;
        end
        apply_cmd(sfu_pkg::CMD_IDLE);
        check_bit("done_o", 1'b0, done_o);
        apply_cmd(other_cmd);
        check_bit("done_o", 1'b0, done_o);
        check_acc_vec("result_o", expected, result_o);
        $display("test %0d mask %b frames %0d..%0d cmd %0d: %0d errors", idx,
                 rows[idx].cfg.macro_mask, rows[idx].cfg.time_first,
                 rows[idx].cfg.time_last, rows[idx].act_cmd, errors - err_start);
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int i;
        cmd        = sfu_pkg::CMD_IDLE;
        splice_cfg = '0;
        rd_data    = '0;
        errors     = 0;
        checks     = 0;
        rows[0] = make_row(4'b1111, 0, 7, sfu_pkg::CMD_ACT_OUTPUT, 1'b0);
        rows[1] = make_row(4'b0101, 2, 5, sfu_pkg::CMD_ACT_HIDDEN, 1'b0);
        rows[2] = make_row(4'b0000, 0, 7, sfu_pkg::CMD_ACT_HIDDEN, 1'b0);
        rows[3] = make_row(4'b1111, 0, 7, sfu_pkg::CMD_ACT_HIDDEN, 1'b1);
        rows[4] = make_row(4'b1010, 1, 6, sfu_pkg::CMD_ACT_OUTPUT, 1'b1);
        rows[5] = make_row(4'b0011, 3, 3, sfu_pkg::CMD_ACT_OUTPUT, 1'b0);
        // empty window, first frame after last
        rows[6] = make_row(4'b1111, 6, 2, sfu_pkg::CMD_ACT_OUTPUT, 1'b0);
        @(posedge clk);
        while (RSTn) begin
            @(posedge clk);
        end
        @(negedge clk);
        check_bit("rd_en_o", 1'b0, rd_en_o);
        check_bit("done_o", 1'b0, done_o);
        check_acc_vec("result_o", '0, result_o);
        for (i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
